//--- include/mat_ledger_cfg.svh
`ifndef MAT_LEDGER_CFG_SVH
`define MAT_LEDGER_CFG_SVH

// ============================================================
// Ledger geometry
// ============================================================

// Number of shape entries in the table
`define LEDGER_MAX_TYPES 25

// Bits per matrix dimension
`define LEDGER_DIM_W 4

// Matrix memory
`define LEDGER_ADDR_W 9
`define LEDGER_MEM_WORDS 512

// Ping-pong copies kept per shape
`define LEDGER_COPIES 2

`endif

//--- source/mat_ledger_pkg.sv
`include "mat_ledger_cfg.svh"

package mat_ledger_pkg;

    typedef enum logic {
        OP_ALLOC  = 1'b0,
        OP_SELECT = 1'b1
    } op_t;

    typedef enum logic [2:0] {
        ST_OK        = 3'd0,
        ST_NEW       = 3'd1,
        ST_FULL      = 3'd2,
        ST_NOT_FOUND = 3'd3,
        ST_BAD_ID    = 3'd4,
        ST_BAD_REQ   = 3'd5
    } status_t;

    typedef struct packed {
        logic [`LEDGER_DIM_W-1:0] rows;
        logic [`LEDGER_DIM_W-1:0] cols;
    } dims_t;

    typedef logic [1:0]                  copy_id_t;
    typedef logic [`LEDGER_ADDR_W-1:0]   addr_t;
    typedef logic [2*`LEDGER_DIM_W-1:0]  size_t;
    typedef logic [4:0]                  type_count_t;
    typedef logic [5:0]                  total_count_t;

    typedef struct packed {
        op_t      op;
        dims_t    dims;
        copy_id_t copy_id;
    } ledger_req_t;

    typedef struct packed {
        op_t     op;
        status_t status;
        addr_t   addr;
    } ledger_rsp_t;

    // Request as seen by the slots and the collector
    typedef struct packed {
        op_t      op;
        dims_t    dims;
        copy_id_t copy_id;
        size_t    size;
        addr_t    offset;
        status_t  pre_status;
        addr_t    footprint;
    } stage_t;

    typedef struct packed {
        logic       hit;
        logic       id_ok;
        addr_t      alloc_addr;
        addr_t      select_addr;
        logic [1:0] count;
    } slot_view_t;

endpackage

//--- source/ledger_dispatch.sv
module ledger_dispatch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_req_stb,
    input  mat_ledger_pkg::ledger_req_t i_req,
    input  mat_ledger_pkg::type_count_t i_types_count,
    output logic                        o_stage_stb,
    output logic                        o_probe_stb,
    output mat_ledger_pkg::stage_t      o_stage
);

    import mat_ledger_pkg::*;

    size_t   req_size;
    addr_t   req_footprint;
    addr_t   req_offset;
    logic    dims_zero;
    logic    bad_select;
    status_t req_pre_status;

    // ============================================================
    // Request arithmetic
    // ============================================================
    always_comb begin
        req_size      = size_t'(i_req.dims.rows) * size_t'(i_req.dims.cols);
        // Both copies of the shape
        req_footprint = addr_t'(req_size) << 1;

        // Copy 1 at the base, copy 2 one matrix above
        if (i_req.copy_id == 2'd0) begin
            req_offset = '0;
        end else begin
            req_offset = addr_t'(i_req.copy_id - 2'd1) * addr_t'(req_size);
        end
    end

    // ============================================================
    // Pre-checks
    // ============================================================
    always_comb begin
        dims_zero  = (i_req.dims.rows == '0) || (i_req.dims.cols == '0);
        // Nothing to select from an empty ledger
        bad_select = (i_req.op == OP_SELECT) &&
                     ((i_req.copy_id == 2'd0) || (i_types_count == '0));

        if (dims_zero || bad_select) begin
            req_pre_status = ST_BAD_REQ;
        end else begin
            req_pre_status = ST_OK;
        end
    end

    // ============================================================
    // Stage register
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_stage_stb <= 1'b0;
            o_probe_stb <= 1'b0;
        end else begin
            o_stage_stb <= i_req_stb;
            // Rejected requests bypass the slots
            o_probe_stb <= i_req_stb && (req_pre_status == ST_OK);
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_stb) begin
            o_stage.op         <= i_req.op;
            o_stage.dims       <= i_req.dims;
            o_stage.copy_id    <= i_req.copy_id;
            o_stage.size       <= req_size;
            o_stage.offset     <= req_offset;
            o_stage.pre_status <= req_pre_status;
            o_stage.footprint  <= req_footprint;
        end
    end

endmodule

//--- source/ledger_slot.sv
`include "mat_ledger_cfg.svh"

module ledger_slot (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_probe_stb,
    input  mat_ledger_pkg::stage_t     i_stage,
    input  logic                       i_load,
    input  mat_ledger_pkg::addr_t      i_load_base,
    output mat_ledger_pkg::slot_view_t o_view
);

    import mat_ledger_pkg::*;

    localparam logic [1:0] MAX_COUNT = 2'(`LEDGER_COPIES);

    dims_t      ent_dims;
    addr_t      ent_base;
    logic       ent_pp;
    logic [1:0] ent_count;
    logic       alloc_hit;

    // ============================================================
    // Combinational view of this entry
    // ============================================================
    always_comb begin
        // Empty entry never matches
        o_view.hit   = (ent_count != 2'd0) && (ent_dims == i_stage.dims);
        o_view.id_ok = (i_stage.copy_id <= ent_count);

        if (ent_pp) begin
            o_view.alloc_addr = ent_base + addr_t'(i_stage.size);
        end else begin
            o_view.alloc_addr = ent_base;
        end

        o_view.select_addr = ent_base + i_stage.offset;
        o_view.count       = ent_count;
    end

    assign alloc_hit = i_probe_stb && (i_stage.op == OP_ALLOC) && o_view.hit;

    // ============================================================
    // Entry state
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_pp    <= 1'b0;
            ent_count <= 2'd0;
        end else if (i_load) begin
            // First copy already sits at the base
            ent_pp    <= 1'b1;
            ent_count <= 2'd1;
        end else if (alloc_hit) begin
            ent_pp <= ~ent_pp;
            if (ent_count < MAX_COUNT) begin
                ent_count <= ent_count + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            ent_dims <= i_stage.dims;
            ent_base <= i_load_base;
        end
    end

    a_count_cap: assert property (@(posedge clk) disable iff (!rst_n)
        ent_count <= MAX_COUNT);

    // Collector only claims an entry on a table-wide miss
    a_load_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        i_load |-> !o_view.hit);

endmodule

//--- source/ledger_collect.sv
`include "mat_ledger_cfg.svh"

module ledger_collect (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               i_stage_stb,
    input  logic                                               i_probe_stb,
    input  mat_ledger_pkg::stage_t                             i_stage,
    input  mat_ledger_pkg::slot_view_t [`LEDGER_MAX_TYPES-1:0] i_views,
    output logic [`LEDGER_MAX_TYPES-1:0]                       o_load,
    output mat_ledger_pkg::addr_t                              o_load_base,
    output mat_ledger_pkg::type_count_t                        o_types_count,
    output mat_ledger_pkg::total_count_t                       o_total_count,
    output logic                                               o_rsp_stb,
    output mat_ledger_pkg::ledger_rsp_t                        o_rsp
);

    import mat_ledger_pkg::*;

    localparam int N     = `LEDGER_MAX_TYPES;
    localparam int PTR_W = `LEDGER_ADDR_W + 1;
    localparam logic [PTR_W-1:0] MEM_END = PTR_W'(`LEDGER_MEM_WORDS);

    logic [N-1:0]     hits;
    logic             any_hit;
    logic             hit_id_ok;
    addr_t            hit_alloc_addr;
    addr_t            hit_select_addr;
    total_count_t     total_sum;
    logic [PTR_W-1:0] free_ptr;
    logic [PTR_W-1:0] next_ptr;
    logic             has_room;
    logic             fits;
    logic             do_new;
    status_t          rsp_status;
    addr_t            rsp_addr;

    // ============================================================
    // Merge slot views
    // ============================================================
    always_comb begin
        hit_id_ok       = 1'b0;
        hit_alloc_addr  = '0;
        hit_select_addr = '0;
        total_sum       = '0;
        for (int i = 0; i < N; i++) begin
            hits[i]   = i_views[i].hit;
            total_sum = total_sum + total_count_t'(i_views[i].count);
            if (i_views[i].hit) begin
                hit_id_ok       = hit_id_ok | i_views[i].id_ok;
                hit_alloc_addr  = hit_alloc_addr | i_views[i].alloc_addr;
                hit_select_addr = hit_select_addr | i_views[i].select_addr;
            end
        end
    end

    assign any_hit       = |hits;
    assign o_total_count = total_sum;

    // New entry allocation
    assign next_ptr = free_ptr + PTR_W'(i_stage.footprint);
    assign has_room = o_types_count < type_count_t'(N);
    assign fits     = next_ptr <= MEM_END;
    assign do_new   = i_probe_stb && (i_stage.op == OP_ALLOC) && !any_hit && has_room && fits;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            o_load[i] = do_new && (o_types_count == type_count_t'(i));
        end
    end

    assign o_load_base = free_ptr[`LEDGER_ADDR_W-1:0];

    // ============================================================
    // Response decode
    // ============================================================
    always_comb begin
        rsp_status = i_stage.pre_status;
        rsp_addr   = '0;
        if (i_probe_stb) begin
            if (i_stage.op == OP_ALLOC) begin
                if (any_hit) begin
                    rsp_status = ST_OK;
                    rsp_addr   = hit_alloc_addr;
                end else if (do_new) begin
                    rsp_status = ST_NEW;
                    rsp_addr   = o_load_base;
                end else begin
                    rsp_status = ST_FULL;
                end
            end else if (any_hit && hit_id_ok) begin
                rsp_status = ST_OK;
                rsp_addr   = hit_select_addr;
            end else if (any_hit) begin
                rsp_status = ST_BAD_ID;
            end else begin
                rsp_status = ST_NOT_FOUND;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rsp_stb     <= 1'b0;
            o_types_count <= '0;
            free_ptr      <= '0;
        end else begin
            o_rsp_stb <= i_stage_stb;
            if (do_new) begin
                o_types_count <= o_types_count + type_count_t'(1);
                free_ptr      <= next_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_stage_stb) begin
            o_rsp.op     <= i_stage.op;
            o_rsp.status <= rsp_status;
            o_rsp.addr   <= rsp_addr;
        end
    end

    // Slots never hold the same shape twice
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        i_probe_stb |-> $onehot0(hits));

endmodule

//--- source/mat_ledger_top.sv
`include "mat_ledger_cfg.svh"

module mat_ledger_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_req_stb,
    input  mat_ledger_pkg::ledger_req_t  i_req,
    output logic                         o_rsp_stb,
    output mat_ledger_pkg::ledger_rsp_t  o_rsp,
    output mat_ledger_pkg::type_count_t  o_types_count,
    output mat_ledger_pkg::total_count_t o_total_count
);

    import mat_ledger_pkg::*;

    logic                                stage_stb;
    logic                                probe_stb;
    stage_t                              stage;
    slot_view_t [`LEDGER_MAX_TYPES-1:0]  views;
    logic [`LEDGER_MAX_TYPES-1:0]        load;
    addr_t                               load_base;

    ledger_dispatch u_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req_stb     (i_req_stb),
        .i_req         (i_req),
        .i_types_count (o_types_count),
        .o_stage_stb   (stage_stb),
        .o_probe_stb   (probe_stb),
        .o_stage       (stage)
    );

    // One entry per ledger row
    for (genvar g = 0; g < `LEDGER_MAX_TYPES; g++) begin : g_slot
        ledger_slot u_slot (
            .clk         (clk),
            .rst_n       (rst_n),
            .i_probe_stb (probe_stb),
            .i_stage     (stage),
            .i_load      (load[g]),
            .i_load_base (load_base),
            .o_view      (views[g])
        );
    end

    ledger_collect u_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_stage_stb   (stage_stb),
        .i_probe_stb   (probe_stb),
        .i_stage       (stage),
        .i_views       (views),
        .o_load        (load),
        .o_load_base   (load_base),
        .o_types_count (o_types_count),
        .o_total_count (o_total_count),
        .o_rsp_stb     (o_rsp_stb),
        .o_rsp         (o_rsp)
    );

endmodule

//--- testbench/tb_mat_ledger.sv
`include "mat_ledger_cfg.svh"

module tb_mat_ledger;

    timeunit 1ns;
    timeprecision 100ps;

    import mat_ledger_pkg::*;

    localparam int          HALF_PERIOD  = 10;
    localparam int          RESET_CYCLES = 5;
    localparam int          LATENCY      = 2;
    localparam int          TIMEOUT      = 20;
    localparam int          NUM_ROWS     = 15;
    localparam logic [31:0] LFSR_SEED    = 32'h8cb7ea55;

    typedef struct packed {
        op_t          op;
        dims_t        dims;
        copy_id_t     copy_id;
        status_t      exp_status;
        addr_t        exp_addr;
        type_count_t  exp_types;
        total_count_t exp_total;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         i_req_stb;
    ledger_req_t  i_req;
    logic         o_rsp_stb;
    ledger_rsp_t  o_rsp;
    type_count_t  o_types_count;
    total_count_t o_total_count;

    row_t         table_rows [NUM_ROWS];
    logic [31:0]  lfsr_state;

    mat_ledger_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req_stb     (i_req_stb),
        .i_req         (i_req),
        .o_rsp_stb     (o_rsp_stb),
        .o_rsp         (o_rsp),
        .o_types_count (o_types_count),
        .o_total_count (o_total_count)
    );

    always #HALF_PERIOD clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    function automatic row_t make_row(input op_t op, input int rows, input int cols,
                                      input int id, input status_t st, input int addr,
                                      input int types, input int total);
        row_t r;
        r.op         = op;
        r.dims.rows  = `LEDGER_DIM_W'(rows);
        r.dims.cols  = `LEDGER_DIM_W'(cols);
        r.copy_id    = copy_id_t'(id);
        r.exp_status = st;
        r.exp_addr   = addr_t'(addr);
        r.exp_types  = type_count_t'(types);
        r.exp_total  = total_count_t'(total);
        return r;
    endfunction

    task automatic next_gap(output int gap);
        logic b0;
        logic b1;
        lfsr_state = lfsr_next(lfsr_state);
        b0 = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        b1 = lfsr_state[0];
        gap = int'({b1, b0});
    endtask

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_op(input string name, input op_t exp, input op_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%s got=%s", $time, name, exp.name(), act.name());
            stop_with_failure();
        end
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%s got=%s", $time, name, exp.name(), act.name());
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%0d got=%0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_types(input string name, input type_count_t exp,
                               input type_count_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%0d got=%0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_total(input string name, input total_count_t exp,
                               input total_count_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s exp=%0d got=%0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(input int act);
        if (act != LATENCY) begin
            $display("ERR t=%0t rsp_latency exp=%0d got=%0d", $time, LATENCY, act);
            stop_with_failure();
        end
    endtask

    // Call right after a falling edge
    task automatic start_req(input row_t row);
        i_req_stb     = 1'b1;
        i_req.op      = row.op;
        i_req.dims    = row.dims;
        i_req.copy_id = row.copy_id;
    endtask

    // Counts falling edges until the response strobe shows up
    task automatic wait_rsp(output int cycles);
        cycles = 0;
        while (o_rsp_stb !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("No response strobe within %0d cycles at t=%0t", TIMEOUT, $time);
                stop_with_failure();
            end
        end
    endtask

    task automatic check_rsp(input row_t row);
        check_op("o_rsp.op", row.op, o_rsp.op);
        check_status("o_rsp.status", row.exp_status, o_rsp.status);
        check_addr("o_rsp.addr", row.exp_addr, o_rsp.addr);
        check_types("o_types_count", row.exp_types, o_types_count);
        check_total("o_total_count", row.exp_total, o_total_count);
    endtask

    task automatic fill_table();
        // 3x4 is 12 words, free pointer goes to 24
        table_rows[0]  = make_row(OP_ALLOC,  3,  4, 1, ST_NEW,         0, 1, 1);
        table_rows[1]  = make_row(OP_ALLOC,  3,  4, 1, ST_OK,         12, 1, 2);
        // Count saturates at two
        table_rows[2]  = make_row(OP_ALLOC,  3,  4, 1, ST_OK,          0, 1, 2);
        table_rows[3]  = make_row(OP_SELECT, 3,  4, 2, ST_OK,         12, 1, 2);
        table_rows[4]  = make_row(OP_SELECT, 3,  4, 1, ST_OK,          0, 1, 2);
        table_rows[5]  = make_row(OP_SELECT, 2,  2, 1, ST_NOT_FOUND,   0, 1, 2);
        table_rows[6]  = make_row(OP_ALLOC,  0,  4, 1, ST_BAD_REQ,     0, 1, 2);
        table_rows[7]  = make_row(OP_SELECT, 3,  4, 0, ST_BAD_REQ,     0, 1, 2);
        // 225 words, pointer 24 -> 474
        table_rows[8]  = make_row(OP_ALLOC, 15, 15, 1, ST_NEW,        24, 2, 3);
        table_rows[9]  = make_row(OP_SELECT, 3,  4, 3, ST_BAD_ID,      0, 2, 3);
        table_rows[10] = make_row(OP_SELECT, 15, 15, 2, ST_BAD_ID,     0, 2, 3);
        // Pointer 474 -> 506
        table_rows[11] = make_row(OP_ALLOC,  4,  4, 1, ST_NEW,       474, 3, 4);
        // 506 + 8 overruns 512
        table_rows[12] = make_row(OP_ALLOC,  2,  2, 1, ST_FULL,        0, 3, 4);
        table_rows[13] = make_row(OP_SELECT, 4,  4, 1, ST_OK,        474, 3, 4);
        table_rows[14] = make_row(OP_SELECT, 15, 15, 1, ST_OK,        24, 3, 4);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int   gap;
        int   cycles;
        row_t pair_a;
        row_t pair_b;

        clk        = 1'b0;
        rst_n      = 1'b0;
        i_req_stb  = 1'b0;
        i_req      = '0;
        lfsr_state = LFSR_SEED;
        fill_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        if (o_rsp_stb !== 1'b0) begin
            $display("Response strobe is active right after reset");
            stop_with_failure();
        end
        check_types("o_types_count", type_count_t'(0), o_types_count);
        check_total("o_total_count", total_count_t'(0), o_total_count);

        for (int i = 0; i < NUM_ROWS; i++) begin
            next_gap(gap);
            repeat (gap) @(negedge clk);
            start_req(table_rows[i]);
            @(negedge clk);
            i_req_stb = 1'b0;
            wait_rsp(cycles);
            // Counting began one cycle after the request
            check_latency(cycles + 1);
            check_rsp(table_rows[i]);
        end

        // Back-to-back allocs of a fresh 1x1 shape
        pair_a = make_row(OP_ALLOC, 1, 1, 1, ST_NEW, 506, 4, 5);
        pair_b = make_row(OP_ALLOC, 1, 1, 1, ST_OK,  507, 4, 6);
        @(negedge clk);
        start_req(pair_a);
        @(negedge clk);
        start_req(pair_b);
        @(negedge clk);
        i_req_stb = 1'b0;
        wait_rsp(cycles);
        // Counting began two cycles after the first request
        check_latency(cycles + 2);
        check_rsp(pair_a);

        @(negedge clk);
        if (o_rsp_stb !== 1'b1) begin
            $display("Second response did not follow on the next cycle at t=%0t", $time);
            stop_with_failure();
        end
        check_rsp(pair_b);

        @(negedge clk);
        if (o_rsp_stb !== 1'b0) begin
            $display("Response strobe stayed high after the last response at t=%0t", $time);
            stop_with_failure();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
source/mat_ledger_pkg.sv
source/ledger_dispatch.sv
source/ledger_slot.sv
source/ledger_collect.sv
source/mat_ledger_top.sv
testbench/tb_mat_ledger.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mat_ledger
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
